// ==== list.f ====
+incdir+logic
logic/raster_pkg.sv
logic/triangle_setup.sv
logic/edge_walker.sv
logic/fb_arbiter.sv
logic/frame_buffer.sv
logic/raster_top.sv
test/raster_tb.sv

// ==== test/raster_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "raster_params.svh"

module raster_tb;

    import raster_pkg::*;

    localparam int DEPTH        = `FB_W * `FB_H;
    localparam int DONE_LIMIT   = 5000;
    localparam int RVALID_LIMIT = 8;

    logic     clk;
    logic     reset;
    coord_t   x0;
    coord_t   y0;
    coord_t   x1;
    coord_t   y1;
    coord_t   x2;
    coord_t   y2;
    color_t   tri_color;
    logic     tri_start;
    logic     busy;
    logic     done;
    logic     host_req;
    logic     host_we;
    fb_addr_t host_addr;
    color_t   host_wdata;
    color_t   host_rdata;
    logic     host_rvalid;

    color_t      model_img [DEPTH];
    logic [31:0] lfsr;
    int          rv_x [3];
    int          rv_y [3];
    color_t      rv_col;

    raster_top u_dut
    (
        .clk(clk), .reset(reset),
        .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
        .tri_color(tri_color), .tri_start(tri_start), .busy(busy), .done(done),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_rvalid(host_rvalid)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare_pixel(input int addr, input color_t got, input color_t exp);
        assert (got == exp)
        else
        begin
            $display("** Error at %0t: address %0d expected %02h read %02h",
                     $time, addr, exp, got);
            abort_run();
        end
    endtask

    task automatic write_word(input int addr, input color_t data);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= fb_addr_t'(addr);
        host_wdata <= data;
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic read_word(input int addr, output color_t data);
        int   cycles;
        logic seen;
        @(posedge clk);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= fb_addr_t'(addr);
        @(posedge clk);
        host_req <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RVALID_LIMIT)
        begin
            @(negedge clk);
            seen = host_rvalid;
            cycles++;
        end
        if (!seen)
        begin
            $display("Timeout waiting for host_rvalid on read of address %0d", addr);
            abort_run();
        end
        data = host_rdata;
    endtask

    task automatic check_image();
        color_t got;
        for (int a = 0; a < DEPTH; a++)
        begin
            read_word(a, got);
            compare_pixel(a, got, model_img[a]);
        end
    endtask

    task automatic clear_buffer();
        for (int a = 0; a < DEPTH; a++)
        begin
            write_word(a, '0);
            model_img[a] = '0;
        end
    endtask

    task automatic start_triangle(input int ax, input int ay, input int bx, input int by,
                                  input int cx, input int cy, input color_t col);
        @(posedge clk);
        x0        <= coord_t'(ax);
        y0        <= coord_t'(ay);
        x1        <= coord_t'(bx);
        y1        <= coord_t'(by);
        x2        <= coord_t'(cx);
        y2        <= coord_t'(cy);
        tri_color <= col;
        tri_start <= 1'b1;
        @(posedge clk);
        tri_start <= 1'b0;
    endtask

    // Single done pulse while busy, then busy drops one cycle later
    task automatic wait_done();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_LIMIT)
        begin
            @(negedge clk);
            seen = done;
            cycles++;
        end
        if (!seen)
        begin
            $display("Timeout waiting for done after %0d cycles", cycles);
            abort_run();
        end
        assert (busy)
        else
        begin
            $display("busy was low in the cycle of done");
            abort_run();
        end
        @(negedge clk);
        assert (!busy && !done)
        else
        begin
            $display("busy or done still high one cycle after done");
            abort_run();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    task automatic draw_model(input int ax, input int ay, input int bx, input int by,
                              input int cx, input int cy, input color_t col);
        int vx [3];
        int vy [3];
        int e [3];
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        int j;
        vx = '{ax, bx, cx};
        vy = '{ay, by, cy};
        lo_x = (ax < bx) ? ((ax < cx) ? ax : cx) : ((bx < cx) ? bx : cx);
        hi_x = (ax > bx) ? ((ax > cx) ? ax : cx) : ((bx > cx) ? bx : cx);
        lo_y = (ay < by) ? ((ay < cy) ? ay : cy) : ((by < cy) ? by : cy);
        hi_y = (ay > by) ? ((ay > cy) ? ay : cy) : ((by > cy) ? by : cy);
        if (lo_x < 0)
            lo_x = 0;
        if (lo_y < 0)
            lo_y = 0;
        if (hi_x > `FB_W - 1)
            hi_x = `FB_W - 1;
        if (hi_y > `FB_H - 1)
            hi_y = `FB_H - 1;
        for (int y = lo_y; y <= hi_y; y++)
        begin
            for (int x = lo_x; x <= hi_x; x++)
            begin
                for (int i = 0; i < 3; i++)
                begin
                    j = (i + 1) % 3;
                    e[i] = (x - vx[i]) * (vy[j] - vy[i]) - (y - vy[i]) * (vx[j] - vx[i]);
                end
                if (e[0] >= 0 && e[1] >= 0 && e[2] >= 0)
                    model_img[y * `FB_W + x] = col;
            end
        end
    endtask

    // Vertices in -8..55 with the winding flipped to cover pixels
    task automatic make_random_triangle();
        int v;
        int area2;
        for (int i = 0; i < 3; i++)
        begin
            take_bits(6, v);
            rv_x[i] = v - 8;
            take_bits(6, v);
            rv_y[i] = v - 8;
        end
        take_bits(8, v);
        rv_col = color_t'(v) | color_t'(1);
        area2 = (rv_x[1] - rv_x[0]) * (rv_y[2] - rv_y[0])
              - (rv_y[1] - rv_y[0]) * (rv_x[2] - rv_x[0]);
        if (area2 > 0)
        begin
            v = rv_x[1];
            rv_x[1] = rv_x[2];
            rv_x[2] = v;
            v = rv_y[1];
            rv_y[1] = rv_y[2];
            rv_y[2] = v;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin
        lfsr       = 32'ha5f8_d486;
        reset      <= 1'b1;
        x0         <= '0;
        y0         <= '0;
        x1         <= '0;
        y1         <= '0;
        x2         <= '0;
        y2         <= '0;
        tri_color  <= '0;
        tri_start  <= 1'b0;
        host_req   <= 1'b0;
        host_we    <= 1'b0;
        host_addr  <= '0;
        host_wdata <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Address pattern, then clear
        for (int a = 0; a < DEPTH; a++)
        begin
            write_word(a, color_t'(a ^ (a >> 8)));
            model_img[a] = color_t'(a ^ (a >> 8));
        end
        check_image();
        clear_buffer();
        check_image();

        // Single triangle
        start_triangle(2, 3, 5, 25, 28, 9, 8'h5a);
        draw_model(2, 3, 5, 25, 28, 9, 8'h5a);
        wait_done();
        check_image();

        // Reversed winding writes nothing
        clear_buffer();
        start_triangle(0, 0, 10, 0, 0, 10, 8'hc3);
        draw_model(0, 0, 10, 0, 0, 10, 8'hc3);
        wait_done();
        check_image();

        // Partly off screen
        start_triangle(-5, -6, -3, 40, 45, 10, 8'h3c);
        draw_model(-5, -6, -3, 40, 45, 10, 8'h3c);
        wait_done();
        check_image();

        // Host holds the port so the walker stalls on its first covered pixel
        @(posedge clk);
        x0        <= coord_t'(4);
        y0        <= coord_t'(2);
        x1        <= coord_t'(6);
        y1        <= coord_t'(28);
        x2        <= coord_t'(27);
        y2        <= coord_t'(15);
        tri_color <= 8'h96;
        tri_start <= 1'b1;
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= '0;
        for (int a = 1; a <= DEPTH; a++)
        begin
            @(posedge clk);
            tri_start <= 1'b0;
            if (a < DEPTH)
                host_addr <= fb_addr_t'(a);
            else
                host_req <= 1'b0;
            @(negedge clk);
            assert (host_rvalid && !done)
            else
            begin
                $display("Streamed read %0d lost host_rvalid or saw done early", a - 1);
                abort_run();
            end
            compare_pixel(a - 1, host_rdata, model_img[a - 1]);
        end
        draw_model(4, 2, 6, 28, 27, 15, 8'h96);
        wait_done();
        check_image();

        // Random sequence with one start while busy
        for (int t = 0; t < 4; t++)
        begin
            make_random_triangle();
            start_triangle(rv_x[0], rv_y[0], rv_x[1], rv_y[1], rv_x[2], rv_y[2], rv_col);
            draw_model(rv_x[0], rv_y[0], rv_x[1], rv_y[1], rv_x[2], rv_y[2], rv_col);
            if (t == 1)
            begin
                @(negedge clk);
                assert (busy)
                else
                begin
                    $display("busy was low right after an accepted start");
                    abort_run();
                end
                start_triangle(0, 0, 0, 31, 31, 16, 8'hee);
            end
            wait_done();
        end
        check_image();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/raster_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module raster_top
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire raster_pkg::coord_t   x0,
    input  wire raster_pkg::coord_t   y0,
    input  wire raster_pkg::coord_t   x1,
    input  wire raster_pkg::coord_t   y1,
    input  wire raster_pkg::coord_t   x2,
    input  wire raster_pkg::coord_t   y2,
    input  wire raster_pkg::color_t   tri_color,
    input  wire                       tri_start,
    output logic                      busy,
    output logic                      done,
    input  wire                       host_req,
    input  wire                       host_we,
    input  wire raster_pkg::fb_addr_t host_addr,
    input  wire raster_pkg::color_t   host_wdata,
    output raster_pkg::color_t        host_rdata,
    output logic                      host_rvalid
);

    import raster_pkg::*;

    logic     setup_valid;
    logic     box_empty;
    coord_t   min_x;
    coord_t   max_x;
    coord_t   min_y;
    coord_t   max_y;
    edge_t    dx0;
    edge_t    dy0;
    edge_t    dx1;
    edge_t    dy1;
    edge_t    dx2;
    edge_t    dy2;
    edge_t    e0_init;
    edge_t    e1_init;
    edge_t    e2_init;
    color_t   color_q;
    logic     pix_req;
    fb_addr_t pix_addr;
    color_t   pix_color;
    logic     pix_gnt;
    logic     mem_en;
    logic     mem_we;
    fb_addr_t mem_addr;
    color_t   mem_wdata;

    ////////////////////
    // Triangle path
    ////////////////////

    triangle_setup u_setup
    (
        .clk(clk), .reset(reset), .tri_start(tri_start), .busy(busy),
        .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
        .tri_color(tri_color), .setup_valid(setup_valid), .box_empty(box_empty),
        .min_x(min_x), .max_x(max_x), .min_y(min_y), .max_y(max_y),
        .dx0(dx0), .dy0(dy0), .dx1(dx1), .dy1(dy1), .dx2(dx2), .dy2(dy2),
        .e0_init(e0_init), .e1_init(e1_init), .e2_init(e2_init), .color_q(color_q)
    );

    edge_walker u_walker
    (
        .clk(clk), .reset(reset), .setup_valid(setup_valid), .box_empty(box_empty),
        .min_x(min_x), .max_x(max_x), .min_y(min_y), .max_y(max_y),
        .dx0(dx0), .dy0(dy0), .dx1(dx1), .dy1(dy1), .dx2(dx2), .dy2(dy2),
        .e0_init(e0_init), .e1_init(e1_init), .e2_init(e2_init), .color_q(color_q),
        .pix_req(pix_req), .pix_addr(pix_addr), .pix_color(pix_color),
        .pix_gnt(pix_gnt), .busy(busy), .done(done)
    );

    ////////////////////
    // Memory side
    ////////////////////

    fb_arbiter u_arbiter
    (
        .clk(clk), .reset(reset), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_rvalid(host_rvalid),
        .pix_req(pix_req), .pix_addr(pix_addr), .pix_color(pix_color),
        .pix_gnt(pix_gnt), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    frame_buffer u_fb
    (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(host_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "raster_params.svh"

module frame_buffer
(
    input  wire                       clk,
    input  wire                       mem_en,
    input  wire                       mem_we,
    input  wire raster_pkg::fb_addr_t mem_addr,
    input  wire raster_pkg::color_t   mem_wdata,
    output raster_pkg::color_t        mem_rdata
);

    import raster_pkg::*;

    localparam int DEPTH = `FB_W * `FB_H;

    color_t mem [DEPTH];

    ////////////////////
    // Single port
    ////////////////////

    // Read returns the old word on a write cycle
    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
                mem[mem_addr] <= mem_wdata;
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/fb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module fb_arbiter
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       host_req,
    input  wire                       host_we,
    input  wire raster_pkg::fb_addr_t host_addr,
    input  wire raster_pkg::color_t   host_wdata,
    output logic                      host_rvalid,
    input  wire                       pix_req,
    input  wire raster_pkg::fb_addr_t pix_addr,
    input  wire raster_pkg::color_t   pix_color,
    output logic                      pix_gnt,
    output logic                      mem_en,
    output logic                      mem_we,
    output raster_pkg::fb_addr_t      mem_addr,
    output raster_pkg::color_t        mem_wdata
);

    import raster_pkg::*;

    fb_owner_t owner;

    // Host always wins
    always_comb
    begin
        if (host_req)
            owner = OWN_HOST;
        else if (pix_req)
            owner = OWN_RASTER;
        else
            owner = OWN_NONE;
    end

    assign pix_gnt = (owner == OWN_RASTER);

    always_comb
    begin
        mem_en    = (owner != OWN_NONE);
        mem_we    = 1'b0;
        mem_addr  = host_addr;
        mem_wdata = host_wdata;
        if (owner == OWN_HOST)
            mem_we = host_we;
        else if (owner == OWN_RASTER)
        begin
            mem_we    = 1'b1;
            mem_addr  = pix_addr;
            mem_wdata = pix_color;
        end
    end

    // Read data comes out of the memory one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
            host_rvalid <= 1'b0;
        else
            host_rvalid <= (owner == OWN_HOST) && !host_we;
    end

endmodule

`default_nettype wire

// ==== logic/edge_walker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "raster_params.svh"

module edge_walker
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       setup_valid,
    input  wire                       box_empty,
    input  wire raster_pkg::coord_t   min_x,
    input  wire raster_pkg::coord_t   max_x,
    input  wire raster_pkg::coord_t   min_y,
    input  wire raster_pkg::coord_t   max_y,
    input  wire raster_pkg::edge_t    dx0,
    input  wire raster_pkg::edge_t    dy0,
    input  wire raster_pkg::edge_t    dx1,
    input  wire raster_pkg::edge_t    dy1,
    input  wire raster_pkg::edge_t    dx2,
    input  wire raster_pkg::edge_t    dy2,
    input  wire raster_pkg::edge_t    e0_init,
    input  wire raster_pkg::edge_t    e1_init,
    input  wire raster_pkg::edge_t    e2_init,
    input  wire raster_pkg::color_t   color_q,
    output logic                      pix_req,
    output raster_pkg::fb_addr_t      pix_addr,
    output raster_pkg::color_t        pix_color,
    input  wire                       pix_gnt,
    output logic                      busy,
    output logic                      done
);

    import raster_pkg::*;

    raster_state_t state;
    coord_t        x_cnt;
    coord_t        y_cnt;
    edge_t         row_e [3];
    edge_t         cur_e [3];
    edge_t         step_x [3];
    edge_t         step_y [3];
    logic          covered;
    logic          advance;
    logic          last_x;
    logic          last_y;

    // Right step adds dy, row step subtracts dx
    assign step_x = '{dy0, dy1, dy2};
    assign step_y = '{dx0, dx1, dx2};

    assign covered = (cur_e[0] >= 0) && (cur_e[1] >= 0) && (cur_e[2] >= 0);

    // Uncovered pixels never wait on the arbiter
    assign advance = !covered || pix_gnt;
    assign last_x  = (x_cnt == max_x);
    assign last_y  = (y_cnt == max_y);

    assign pix_req   = (state == RS_SPAN) && covered;
    assign pix_addr  = fb_addr_t'(y_cnt * `FB_W + x_cnt);
    assign pix_color = color_q;

    assign busy = setup_valid || (state != RS_IDLE);
    assign done = (state == RS_DONE);

    ////////////////////
    // Scan FSM
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= RS_IDLE;
        else
        begin
            case (state)
                RS_IDLE:
                    if (setup_valid)
                        state <= box_empty ? RS_DONE : RS_ROW;
                RS_ROW:
                    state <= RS_SPAN;
                RS_SPAN:
                    if (advance && last_x)
                        state <= last_y ? RS_DONE : RS_ROW;
                default:
                    state <= RS_IDLE;
            endcase
        end
    end

    ////////////////////
    // Counters and edge values
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (state == RS_IDLE && setup_valid)
        begin
            y_cnt <= min_y;
            row_e <= '{e0_init, e1_init, e2_init};
        end
        else if (state == RS_ROW)
        begin
            x_cnt <= min_x;
            cur_e <= row_e;
        end
        else if (state == RS_SPAN && advance)
        begin
            x_cnt <= x_cnt + coord_t'(1);
            for (int i = 0; i < 3; i++)
                cur_e[i] <= cur_e[i] + step_x[i];
            if (last_x)
            begin
                y_cnt <= y_cnt + coord_t'(1);
                for (int i = 0; i < 3; i++)
                    row_e[i] <= row_e[i] - step_y[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/triangle_setup.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "raster_params.svh"

module triangle_setup
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     tri_start,
    input  wire                     busy,
    input  wire raster_pkg::coord_t x0,
    input  wire raster_pkg::coord_t y0,
    input  wire raster_pkg::coord_t x1,
    input  wire raster_pkg::coord_t y1,
    input  wire raster_pkg::coord_t x2,
    input  wire raster_pkg::coord_t y2,
    input  wire raster_pkg::color_t tri_color,
    output logic                    setup_valid,
    output logic                    box_empty,
    output raster_pkg::coord_t      min_x,
    output raster_pkg::coord_t      max_x,
    output raster_pkg::coord_t      min_y,
    output raster_pkg::coord_t      max_y,
    output raster_pkg::edge_t       dx0,
    output raster_pkg::edge_t       dy0,
    output raster_pkg::edge_t       dx1,
    output raster_pkg::edge_t       dy1,
    output raster_pkg::edge_t       dx2,
    output raster_pkg::edge_t       dy2,
    output raster_pkg::edge_t       e0_init,
    output raster_pkg::edge_t       e1_init,
    output raster_pkg::edge_t       e2_init,
    output raster_pkg::color_t      color_q
);

    import raster_pkg::*;

    coord_t vx [3];
    coord_t vy [3];
    edge_t  ddx [3];
    edge_t  ddy [3];
    edge_t  e_init [3];
    coord_t clip_min_x;
    coord_t clip_max_x;
    coord_t clip_min_y;
    coord_t clip_max_y;
    logic   start_ok;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign vx = '{x0, x1, x2};
    assign vy = '{y0, y1, y2};

    ////////////////////
    // Edge deltas and box
    ////////////////////

    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            ddx[i] = edge_t'(vx[(i + 1) % 3]) - edge_t'(vx[i]);
            ddy[i] = edge_t'(vy[(i + 1) % 3]) - edge_t'(vy[i]);
        end

        // Each side clamped to the screen on its own side only
        clip_min_x = min3(x0, x1, x2);
        clip_max_x = max3(x0, x1, x2);
        clip_min_y = min3(y0, y1, y2);
        clip_max_y = max3(y0, y1, y2);
        if (clip_min_x < 0)
            clip_min_x = '0;
        if (clip_min_y < 0)
            clip_min_y = '0;
        if (clip_max_x > coord_t'(`FB_W - 1))
            clip_max_x = coord_t'(`FB_W - 1);
        if (clip_max_y > coord_t'(`FB_H - 1))
            clip_max_y = coord_t'(`FB_H - 1);

        // Edge functions at the top-left corner of the box
        for (int i = 0; i < 3; i++)
        begin
            e_init[i] = (edge_t'(clip_min_x) - edge_t'(vx[i])) * ddy[i]
                      - (edge_t'(clip_min_y) - edge_t'(vy[i])) * ddx[i];
        end
    end

    ////////////////////
    // Result registers
    ////////////////////

    assign start_ok = tri_start && !busy;

    always_ff @(posedge clk)
    begin
        if (reset)
            setup_valid <= 1'b0;
        else
            setup_valid <= start_ok;
    end

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            box_empty <= (clip_min_x > clip_max_x) || (clip_min_y > clip_max_y);
            min_x     <= clip_min_x;
            max_x     <= clip_max_x;
            min_y     <= clip_min_y;
            max_y     <= clip_max_y;
            dx0       <= ddx[0];
            dy0       <= ddy[0];
            dx1       <= ddx[1];
            dy1       <= ddy[1];
            dx2       <= ddx[2];
            dy2       <= ddy[2];
            e0_init   <= e_init[0];
            e1_init   <= e_init[1];
            e2_init   <= e_init[2];
            color_q   <= tri_color;
        end
    end

endmodule

`default_nettype wire

// ==== logic/raster_pkg.sv ====
`default_nettype none

`include "raster_params.svh"

package raster_pkg;

    // Vertex coordinate, screen space
    typedef logic signed [`COORD_W-1:0] coord_t;

    // Edge function value, wide enough for the coordinate products
    typedef logic signed [31:0] edge_t;

    typedef logic [`COLOR_W-1:0] color_t;

    // Row times FB_W plus column
    typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

    typedef enum logic [1:0]
    {
        RS_IDLE,
        RS_ROW,
        RS_SPAN,
        RS_DONE
    } raster_state_t;

    typedef enum logic [1:0]
    {
        OWN_NONE,
        OWN_HOST,
        OWN_RASTER
    } fb_owner_t;

endpackage

`default_nettype wire

// ==== logic/raster_params.svh ====
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

////////////////////
// Geometry
////////////////////

// Signed vertex coordinate width
`define COORD_W 12

// Screen size in pixels
`define FB_W 32
`define FB_H 32

// Address covers FB_W * FB_H
`define FB_ADDR_W 10

////////////////////
// Pixel format
////////////////////

`define COLOR_W 8

`endif
